/* design/phy_bus_pkg.sv */
// PHY boundary bus definitions
`default_nettype none

package phy_bus_pkg;

  localparam int ADR_W       = 24;
  localparam int DATA_W      = 32;
  localparam int CLK_INDEX_W = 4;

  // training word i lives at base + i
  localparam logic [ADR_W-1:0]  TRAIN_BASE_ADR = 24'h000100;
  // word i is this seed rotated left by i
  localparam logic [DATA_W-1:0] TRAIN_PATTERN  = 32'hA5C3_0F96;

  // master side of wishbone classic
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // pll reconfig request, start is a single-cycle pulse
  typedef struct packed {
    logic                   start;
    logic                   inc_dec_n;
    logic [CLK_INDEX_W-1:0] select;
  } pll_cmd_t;

endpackage

`default_nettype wire

/* design/cal_result_pkg.sv */
// Calibration result types
`default_nettype none

package cal_result_pkg;

  // up to 64 resync phases
  localparam int PHASE_W = 6;

  // request to test the current phase
  typedef struct packed {
    logic               valid;
    logic [PHASE_W-1:0] phase;
  } phase_probe_t;

  typedef struct packed {
    logic               valid;
    logic [PHASE_W-1:0] phase;
    logic               pass;
  } phase_result_t;

  // found and multi hold after valid, valid itself pulses
  typedef struct packed {
    logic               valid;
    logic               found;
    logic               multi;
    logic [PHASE_W-1:0] centre;
  } cal_status_t;

endpackage

`default_nettype wire

/* design/seq_startup_gate.sv */
// Sequencer startup gate
`timescale 1ns/1ns
`default_nettype none

module seq_startup_gate (
  input  wire  seq_clk,
  input  wire  reset_seq_n,
  input  wire  ctl_init_done,
  input  wire  phs_shft_busy,
  output logic seq_enable,
  output logic pll_busy_sync
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_BUSY,
    ST_GO
  } state_t;

  state_t     state;
  logic [1:0] init_sync;
  logic [1:0] busy_sync;

  always_ff @(posedge seq_clk or negedge reset_seq_n)
  begin
    if (!reset_seq_n)
    begin
      init_sync  <= 2'b00;
      // treat the pll as busy until proven otherwise
      busy_sync  <= 2'b11;
      state      <= ST_IDLE;
      seq_enable <= 1'b0;
    end
    else
    begin
      init_sync <= {init_sync[0], ctl_init_done};
      busy_sync <= {busy_sync[0], phs_shft_busy};
      case (state)
        ST_IDLE:
        begin
          if (init_sync[1])
          begin
            if (busy_sync[1])
            begin
              state <= ST_WAIT_BUSY;
            end
            else
            begin
              state      <= ST_GO;
              seq_enable <= 1'b1;
            end
          end
        end
        ST_WAIT_BUSY:
        begin
          if (init_sync[1] && !busy_sync[1])
          begin
            state      <= ST_GO;
            seq_enable <= 1'b1;
          end
        end
        ST_GO:
        begin
          // stays enabled until the next reset
          seq_enable <= 1'b1;
        end
        default:
        begin
          state      <= ST_IDLE;
          seq_enable <= 1'b0;
        end
      endcase
    end
  end

  assign pll_busy_sync = busy_sync[1];

endmodule

`default_nettype wire

/* design/seq_training_port.sv */
// Training pattern bus master
`timescale 1ns/1ns
`default_nettype none

module seq_training_port #(
  parameter int TRAINING_WORDS = 4
) (
  input  wire                           seq_clk,
  input  wire                           reset_seq_n,
  input  wire                           seq_enable,
  input  cal_result_pkg::phase_probe_t  probe,
  input  phy_bus_pkg::wb_rsp_t          wb_rsp,
  output phy_bus_pkg::wb_req_t          wb_req,
  output logic                          write_done,
  output cal_result_pkg::phase_result_t result
);

  import phy_bus_pkg::*;
  import cal_result_pkg::*;

  localparam int IDX_W = (TRAINING_WORDS > 1) ? $clog2(TRAINING_WORDS) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(TRAINING_WORDS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WR_GAP,
    ST_READY,
    ST_READ,
    ST_RD_GAP
  } state_t;

  state_t             state;
  logic [IDX_W-1:0]   idx;
  logic [PHASE_W-1:0] probe_phase;
  logic               match_all;
  logic               word_match;

  function automatic logic [DATA_W-1:0] train_word(input logic [IDX_W-1:0] i);
    return (TRAIN_PATTERN << i) | (TRAIN_PATTERN >> (DATA_W - i));
  endfunction

  // start of a single classic transfer for word i
  function automatic wb_req_t bus_req(input logic we, input logic [IDX_W-1:0] i);
    wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = TRAIN_BASE_ADR + ADR_W'(i);
    req.dat = we ? train_word(i) : '0;
    return req;
  endfunction

  assign word_match = (wb_rsp.dat == train_word(idx));

  always_ff @(posedge seq_clk or negedge reset_seq_n)
  begin
    if (!reset_seq_n)
    begin
      state       <= ST_IDLE;
      wb_req      <= '0;
      write_done  <= 1'b0;
      result      <= '0;
      idx         <= '0;
      probe_phase <= '0;
      match_all   <= 1'b0;
    end
    else
    begin
      result.valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (seq_enable)
          begin
            idx    <= '0;
            wb_req <= bus_req(1'b1, '0);
            state  <= ST_WRITE;
          end
        end
        ST_WRITE:
        begin
          if (wb_rsp.ack)
          begin
            wb_req <= '0;
            if (idx == LAST_IDX)
            begin
              write_done <= 1'b1;
              state      <= ST_READY;
            end
            else
            begin
              idx   <= idx + 1'b1;
              state <= ST_WR_GAP;
            end
          end
        end
        ST_WR_GAP:
        begin
          wb_req <= bus_req(1'b1, idx);
          state  <= ST_WRITE;
        end
        ST_READY:
        begin
          if (probe.valid)
          begin
            probe_phase <= probe.phase;
            idx         <= '0;
            match_all   <= 1'b1;
            wb_req      <= bus_req(1'b0, '0);
            state       <= ST_READ;
          end
        end
        ST_READ:
        begin
          if (wb_rsp.ack)
          begin
            wb_req <= '0;
            if (idx == LAST_IDX)
            begin
              result.valid <= 1'b1;
              result.phase <= probe_phase;
              result.pass  <= match_all & word_match;
              state        <= ST_READY;
            end
            else
            begin
              match_all <= match_all & word_match;
              idx       <= idx + 1'b1;
              state     <= ST_RD_GAP;
            end
          end
        end
        ST_RD_GAP:
        begin
          wb_req <= bus_req(1'b0, idx);
          state  <= ST_READ;
        end
        default:
        begin
          state  <= ST_IDLE;
          wb_req <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/seq_phase_stepper.sv */
// Resync phase sweep stepper
`timescale 1ns/1ns
`default_nettype none

module seq_phase_stepper #(
  parameter int PLL_PHASES = 32
) (
  input  wire                                    seq_clk,
  input  wire                                    reset_seq_n,
  input  wire                                    write_done,
  input  wire                                    pll_busy_sync,
  input  wire  [phy_bus_pkg::CLK_INDEX_W-1:0]    resync_clk_index,
  input  cal_result_pkg::phase_result_t          result,
  input  cal_result_pkg::cal_status_t            status,
  output cal_result_pkg::phase_probe_t           probe,
  output phy_bus_pkg::pll_cmd_t                  pll_cmd,
  output logic                                   cal_done
);

  import cal_result_pkg::*;

  localparam logic [PHASE_W-1:0] LAST_PHASE  = PHASE_W'(PLL_PHASES - 1);
  localparam logic [2:0]         WAIT_CYCLES = 3'd4;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RESULT,
    ST_PLL_CNT,
    ST_PLL_BUSY,
    ST_STATUS,
    ST_DONE
  } state_t;

  state_t             state;
  logic [PHASE_W-1:0] phase;
  logic [PHASE_W-1:0] target;
  logic               returning;
  logic               probe_valid;
  logic               pll_start;
  logic               pll_inc;
  logic [2:0]         wait_cnt;

  always_ff @(posedge seq_clk or negedge reset_seq_n)
  begin
    if (!reset_seq_n)
    begin
      state       <= ST_IDLE;
      phase       <= '0;
      target      <= '0;
      returning   <= 1'b0;
      probe_valid <= 1'b0;
      pll_start   <= 1'b0;
      pll_inc     <= 1'b0;
      wait_cnt    <= '0;
      cal_done    <= 1'b0;
    end
    else
    begin
      probe_valid <= 1'b0;
      pll_start   <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (write_done)
          begin
            probe_valid <= 1'b1;
            state       <= ST_RESULT;
          end
        end
        ST_RESULT:
        begin
          if (result.valid)
          begin
            if (phase == LAST_PHASE)
            begin
              state <= ST_STATUS;
            end
            else
            begin
              pll_start <= 1'b1;
              pll_inc   <= 1'b1;
              phase     <= phase + 1'b1;
              wait_cnt  <= WAIT_CYCLES;
              state     <= ST_PLL_CNT;
            end
          end
        end
        // fixed settle time before busy is trusted
        ST_PLL_CNT:
        begin
          wait_cnt <= wait_cnt - 1'b1;
          if (wait_cnt == 3'd1)
          begin
            state <= ST_PLL_BUSY;
          end
        end
        ST_PLL_BUSY:
        begin
          if (!pll_busy_sync)
          begin
            if (!returning)
            begin
              probe_valid <= 1'b1;
              state       <= ST_RESULT;
            end
            else if (phase == target)
            begin
              cal_done <= 1'b1;
              state    <= ST_DONE;
            end
            else
            begin
              pll_start <= 1'b1;
              pll_inc   <= 1'b0;
              phase     <= phase - 1'b1;
              wait_cnt  <= WAIT_CYCLES;
              state     <= ST_PLL_CNT;
            end
          end
        end
        ST_STATUS:
        begin
          if (status.valid)
          begin
            // no window means stay on the last phase
            returning <= 1'b1;
            target    <= status.found ? status.centre : phase;
            state     <= ST_PLL_BUSY;
          end
        end
        ST_DONE:
        begin
          cal_done <= 1'b1;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign probe.valid = probe_valid;
  assign probe.phase = phase;

  assign pll_cmd.start     = pll_start;
  assign pll_cmd.inc_dec_n = pll_inc;
  assign pll_cmd.select    = resync_clk_index;

endmodule

`default_nettype wire

/* design/seq_window_finder.sv */
// Data valid window finder
`timescale 1ns/1ns
`default_nettype none

module seq_window_finder #(
  parameter int PLL_PHASES = 32
) (
  input  wire                           seq_clk,
  input  wire                           reset_seq_n,
  input  cal_result_pkg::phase_result_t result,
  output cal_result_pkg::cal_status_t   status
);

  import cal_result_pkg::*;

  localparam int LEN_W = PHASE_W + 1;
  localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(PLL_PHASES - 1);

  logic [LEN_W-1:0]   run_len;
  logic [LEN_W-1:0]   best_len;
  logic [1:0]         runs;
  logic [PHASE_W-1:0] run_start;
  logic [PHASE_W-1:0] best_start;
  logic               last_seen;
  logic               fresh;
  logic [LEN_W-1:0]   prev_len;
  logic [LEN_W-1:0]   prev_best;
  logic [1:0]         prev_runs;
  logic [LEN_W-1:0]   next_len;
  logic [LEN_W-1:0]   half_len;

  // phase 0 opens a new sweep
  always_comb
  begin
    fresh     = (result.phase == '0);
    prev_len  = fresh ? '0 : run_len;
    prev_best = fresh ? '0 : best_len;
    prev_runs = fresh ? '0 : runs;
    next_len  = prev_len + 1'b1;
    half_len  = (best_len - 1'b1) >> 1;
  end

  always_ff @(posedge seq_clk or negedge reset_seq_n)
  begin
    if (!reset_seq_n)
    begin
      run_len   <= '0;
      best_len  <= '0;
      runs      <= '0;
      last_seen <= 1'b0;
      status    <= '0;
    end
    else
    begin
      last_seen    <= result.valid && (result.phase == LAST_PHASE);
      status.valid <= last_seen;
      if (result.valid)
      begin
        if (result.pass)
        begin
          run_len <= next_len;
          // strictly longer, so the earlier of equal runs stays
          best_len <= (next_len > prev_best) ? next_len : prev_best;
          if (prev_len == '0)
          begin
            runs <= (prev_runs == 2'd2) ? 2'd2 : prev_runs + 1'b1;
          end
          else
          begin
            runs <= prev_runs;
          end
        end
        else
        begin
          run_len  <= '0;
          best_len <= prev_best;
          runs     <= prev_runs;
        end
      end
      if (last_seen)
      begin
        status.found  <= (best_len != '0);
        status.multi  <= (runs > 2'd1);
        status.centre <= (best_len != '0) ? best_start + PHASE_W'(half_len) : '0;
      end
    end
  end

  // start of the current run and of the best run
  always_ff @(posedge seq_clk)
  begin
    if (result.valid && result.pass)
    begin
      if (prev_len == '0)
      begin
        run_start <= result.phase;
      end
      if (next_len > prev_best)
      begin
        best_start <= (prev_len == '0) ? result.phase : run_start;
      end
    end
  end

endmodule

`default_nettype wire

/* design/calib_sequencer.sv */
// Resync calibration sequencer
`timescale 1ns/1ns
`default_nettype none

module calib_sequencer #(
  parameter int PLL_PHASES     = 32,
  parameter int TRAINING_WORDS = 4
) (
  input  wire                                 seq_clk,
  input  wire                                 reset_seq_n,
  input  wire                                 ctl_init_done,
  input  wire                                 phs_shft_busy,
  input  wire  [phy_bus_pkg::CLK_INDEX_W-1:0] resync_clk_index,
  output phy_bus_pkg::wb_req_t                wb_req,
  input  phy_bus_pkg::wb_rsp_t                wb_rsp,
  output phy_bus_pkg::pll_cmd_t               pll_cmd,
  output logic                                ctl_usr_mode_rdy,
  output logic                                resynchronisation_successful,
  output logic                                rsu_no_dvw_err,
  output logic                                rsu_grt_one_dvw_err,
  output logic [cal_result_pkg::PHASE_W-1:0]  rsu_codvw_phase
);

  import cal_result_pkg::*;

  logic          seq_enable;
  logic          pll_busy_sync;
  logic          write_done;
  logic          cal_done;
  phase_probe_t  probe;
  phase_result_t result;
  cal_status_t   status;

  seq_startup_gate u_startup_gate (
    .seq_clk       (seq_clk),
    .reset_seq_n   (reset_seq_n),
    .ctl_init_done (ctl_init_done),
    .phs_shft_busy (phs_shft_busy),
    .seq_enable    (seq_enable),
    .pll_busy_sync (pll_busy_sync)
  );

  seq_training_port #(
    .TRAINING_WORDS (TRAINING_WORDS)
  ) u_training_port (
    .seq_clk     (seq_clk),
    .reset_seq_n (reset_seq_n),
    .seq_enable  (seq_enable),
    .probe       (probe),
    .wb_rsp      (wb_rsp),
    .wb_req      (wb_req),
    .write_done  (write_done),
    .result      (result)
  );

  seq_phase_stepper #(
    .PLL_PHASES (PLL_PHASES)
  ) u_phase_stepper (
    .seq_clk          (seq_clk),
    .reset_seq_n      (reset_seq_n),
    .write_done       (write_done),
    .pll_busy_sync    (pll_busy_sync),
    .resync_clk_index (resync_clk_index),
    .result           (result),
    .status           (status),
    .probe            (probe),
    .pll_cmd          (pll_cmd),
    .cal_done         (cal_done)
  );

  seq_window_finder #(
    .PLL_PHASES (PLL_PHASES)
  ) u_window_finder (
    .seq_clk     (seq_clk),
    .reset_seq_n (reset_seq_n),
    .result      (result),
    .status      (status)
  );

  assign ctl_usr_mode_rdy             = cal_done;
  assign resynchronisation_successful = status.found;
  // missing window is only known once calibration ends
  assign rsu_no_dvw_err               = cal_done & ~status.found;
  assign rsu_grt_one_dvw_err          = status.multi;
  assign rsu_codvw_phase              = status.centre;

endmodule

`default_nettype wire

/* bench/calib_sequencer_tb.sv */
// Calibration sequencer testbench
`timescale 1ns/1ns
`default_nettype none

module calibration_sequencer_tb;

  import phy_bus_pkg::*;
  import cal_result_pkg::*;

  localparam int PLL_PHASES     = 32;
  localparam int TRAINING_WORDS = 4;
  localparam int TIMEOUT_CYCLES = 6 * PLL_PHASES * 60;

  logic                   seq_clk;
  logic                   reset_seq_n;
  logic                   ctl_init_done;
  logic                   phs_shft_busy;
  logic [CLK_INDEX_W-1:0] resync_clk_index;
  wb_req_t                wb_req;
  wb_rsp_t                wb_rsp;
  pll_cmd_t               pll_cmd;
  logic                   ctl_usr_mode_rdy;
  logic                   resynchronisation_successful;
  logic                   rsu_no_dvw_err;
  logic                   rsu_grt_one_dvw_err;
  logic [PHASE_W-1:0]     rsu_codvw_phase;

  logic [31:0]            lfsr_state;
  int                     errors;
  int                     cycle_count;
  logic [PLL_PHASES-1:0]  pass_set;
  int                     startup_busy;
  logic                   startup_ok;
  // bus and pll model state
  logic [DATA_W-1:0]      mem [TRAINING_WORDS];
  logic                   in_xfer;
  int                     ack_wait;
  int                     busy_left;
  int                     pll_phase;
  int                     incs;
  int                     decs;
  int                     writes;
  int                     reads;
  int                     reads_at [PLL_PHASES];

  calib_sequencer #(
    .PLL_PHASES     (PLL_PHASES),
    .TRAINING_WORDS (TRAINING_WORDS)
  ) UUT (
    .seq_clk                      (seq_clk),
    .reset_seq_n                  (reset_seq_n),
    .ctl_init_done                (ctl_init_done),
    .phs_shft_busy                (phs_shft_busy),
    .resync_clk_index             (resync_clk_index),
    .wb_req                       (wb_req),
    .wb_rsp                       (wb_rsp),
    .pll_cmd                      (pll_cmd),
    .ctl_usr_mode_rdy             (ctl_usr_mode_rdy),
    .resynchronisation_successful (resynchronisation_successful),
    .rsu_no_dvw_err               (rsu_no_dvw_err),
    .rsu_grt_one_dvw_err          (rsu_grt_one_dvw_err),
    .rsu_codvw_phase              (rsu_codvw_phase)
  );

  initial
  begin
    seq_clk = 1'b0;
    forever #2 seq_clk = ~seq_clk;
  end

  // galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit)
    begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | int'(lfsr_step());
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] rotate_left(input logic [DATA_W-1:0] v, input int n);
    logic [DATA_W-1:0] r;
    r = v;
    for (int i = 0; i < n; i++)
    begin
      r = {r[DATA_W-2:0], r[DATA_W-1]};
    end
    return r;
  endfunction

  // windows stop at the last phase
  function automatic logic [PLL_PHASES-1:0] window_mask(input int start, input int len);
    logic [PLL_PHASES-1:0] m;
    m = '0;
    for (int p = start; p < start + len && p < PLL_PHASES; p++)
    begin
      m[p] = 1'b1;
    end
    return m;
  endfunction

  function automatic void reference_window(input logic [PLL_PHASES-1:0] set,
                                           output logic found, output logic multi,
                                           output int centre);
    int len;
    int start;
    int best_len;
    int best_start;
    int runs;
    len        = 0;
    start      = 0;
    best_len   = 0;
    best_start = 0;
    runs       = 0;
    for (int p = 0; p < PLL_PHASES; p++)
    begin
      if (set[p])
      begin
        if (len == 0)
        begin
          start = p;
          runs++;
        end
        len++;
        // first of equal runs wins
        if (len > best_len)
        begin
          best_len   = len;
          best_start = start;
        end
      end
      else
      begin
        len = 0;
      end
    end
    found  = (best_len != 0);
    multi  = (runs > 1);
    centre = found ? best_start + (best_len - 1) / 2 : 0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("failure: %s", what);
  endtask

  task automatic serve_bus();
    int off;
    if (wb_rsp.ack)
    begin
      wb_rsp.ack = 1'b0;
      check_value("wb_req.cyc", wb_req.cyc, 1'b0);
      check_value("wb_req.stb", wb_req.stb, 1'b0);
    end
    else if (in_xfer || (wb_req.cyc && wb_req.stb))
    begin
      if (!in_xfer)
      begin
        in_xfer  = 1'b1;
        ack_wait = take_bits(2);
      end
      if (ack_wait != 0)
      begin
        ack_wait--;
      end
      else
      begin
        in_xfer    = 1'b0;
        wb_rsp.ack = 1'b1;
        off        = int'(wb_req.adr) - int'(TRAIN_BASE_ADR);
        if (wb_req.we)
        begin
          check_value("wb_req.adr", wb_req.adr, TRAIN_BASE_ADR + writes);
          check_value("wb_req.dat", wb_req.dat, rotate_left(TRAIN_PATTERN, writes));
          if (reads != 0)
          begin
            note_failure("training write seen after a read");
          end
          if (off >= 0 && off < TRAINING_WORDS)
          begin
            mem[off] = wb_req.dat;
          end
          writes++;
        end
        else
        begin
          if (reads == 0)
          begin
            check_value("writes before first read", writes, TRAINING_WORDS);
          end
          reads++;
          wb_rsp.dat = '0;
          if (off < 0 || off >= TRAINING_WORDS)
          begin
            note_failure("read outside the training words");
          end
          else if (pll_phase < 0 || pll_phase >= PLL_PHASES)
          begin
            note_failure("read while the PLL is outside the sweep range");
          end
          else
          begin
            reads_at[pll_phase]++;
            wb_rsp.dat = pass_set[pll_phase] ? mem[off] : ~mem[off];
          end
        end
      end
    end
  endtask

  task automatic drive_pll();
    if (pll_cmd.start)
    begin
      if (phs_shft_busy || busy_left != 0)
      begin
        note_failure("PLL pulse issued before busy fell");
      end
      check_value("pll_cmd.select", pll_cmd.select, resync_clk_index);
      if (pll_cmd.inc_dec_n)
      begin
        if (decs != 0)
        begin
          note_failure("PLL increment after the return to centre began");
        end
        incs++;
        pll_phase++;
      end
      else
      begin
        decs++;
        pll_phase--;
      end
      // busy starts on the next cycle
      busy_left = 1 + take_bits(3);
    end
    else if (busy_left != 0)
    begin
      phs_shft_busy = 1'b1;
      busy_left--;
    end
    else
    begin
      phs_shft_busy = 1'b0;
    end
  endtask

  always @(posedge seq_clk)
  begin
    #1;
    if (!reset_seq_n)
    begin
      wb_rsp        = '0;
      in_xfer       = 1'b0;
      ack_wait      = 0;
      phs_shft_busy = 1'b0;
      busy_left     = startup_busy;
      pll_phase     = 0;
      incs          = 0;
      decs          = 0;
      writes        = 0;
      reads         = 0;
      startup_ok    = 1'b0;
      for (int p = 0; p < PLL_PHASES; p++)
      begin
        reads_at[p] = 0;
      end
    end
    else
    begin
      if (!startup_ok && (wb_req.cyc || pll_cmd.start))
      begin
        note_failure("bus or PLL activity before init done with PLL idle");
      end
      startup_ok = startup_ok | (ctl_init_done & ~phs_shft_busy);
      serve_bus();
      drive_pll();
    end
  end

  task automatic apply_reset(input logic [PLL_PHASES-1:0] set);
    @(posedge seq_clk);
    #1;
    reset_seq_n      = 1'b0;
    ctl_init_done    = 1'b0;
    pass_set         = set;
    resync_clk_index = CLK_INDEX_W'(take_bits(CLK_INDEX_W));
    startup_busy     = take_bits(5);
    repeat (8) @(posedge seq_clk);
    #1;
    reset_seq_n = 1'b1;
  endtask

  task automatic run_calibration(input logic [PLL_PHASES-1:0] set);
    int   init_low;
    logic exp_found;
    logic exp_multi;
    int   exp_centre;
    apply_reset(set);
    init_low = 1 + take_bits(4);
    // status outputs keep their reset values while init is low
    repeat (init_low)
    begin
      @(posedge seq_clk);
      #1;
      check_value("ctl_usr_mode_rdy", ctl_usr_mode_rdy, 1'b0);
      check_value("resynchronisation_successful", resynchronisation_successful, 1'b0);
      check_value("rsu_no_dvw_err", rsu_no_dvw_err, 1'b0);
      check_value("rsu_grt_one_dvw_err", rsu_grt_one_dvw_err, 1'b0);
    end
    ctl_init_done = 1'b1;
    while (ctl_usr_mode_rdy !== 1'b1)
    begin
      @(posedge seq_clk);
      #1;
    end
    reference_window(set, exp_found, exp_multi, exp_centre);
    check_value("resynchronisation_successful", resynchronisation_successful, exp_found);
    check_value("rsu_no_dvw_err", rsu_no_dvw_err, !exp_found);
    check_value("rsu_grt_one_dvw_err", rsu_grt_one_dvw_err, exp_multi);
    if (exp_found)
    begin
      check_value("rsu_codvw_phase", rsu_codvw_phase, exp_centre);
    end
    check_value("training writes", writes, TRAINING_WORDS);
    check_value("pll increments", incs, PLL_PHASES - 1);
    check_value("pll decrements", decs, exp_found ? PLL_PHASES - 1 - exp_centre : 0);
    check_value("pll phase", pll_phase, exp_found ? exp_centre : PLL_PHASES - 1);
    for (int p = 0; p < PLL_PHASES; p++)
    begin
      check_value($sformatf("reads at phase %0d", p), reads_at[p], TRAINING_WORDS);
    end
  endtask

  initial
  begin
    int start;
    int len_a;
    int gap;
    int len_b;
    lfsr_state       = 32'd2;
    errors           = 0;
    reset_seq_n      = 1'b0;
    ctl_init_done    = 1'b0;
    phs_shft_busy    = 1'b0;
    resync_clk_index = '0;
    wb_rsp           = '0;
    pass_set         = '0;
    startup_busy     = 0;
    // no passing phase at all
    run_calibration('0);
    // two separate windows
    start = take_bits(3);
    len_a = 2 + take_bits(2);
    gap   = 1 + take_bits(2);
    len_b = 1 + take_bits(3);
    run_calibration(window_mask(start, len_a) | window_mask(start + len_a + gap, len_b));
    repeat (4)
    begin
      start = take_bits(5);
      len_a = 1 + take_bits(5);
      run_calibration(window_mask(start, len_a));
    end
    $display("Errors: %0d", errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge seq_clk);
      cycle_count++;
    end
    note_failure("calibration runs did not finish within the cycle limit");
    $display("Errors: %0d", errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/phy_bus_pkg.sv
design/cal_result_pkg.sv
design/seq_startup_gate.sv
design/seq_training_port.sv
design/seq_phase_stepper.sv
design/seq_window_finder.sv
design/calib_sequencer.sv
bench/calib_sequencer_tb.sv
